//--- design/layer_macros.svh
// Sizes, fraction bits and gain shifts of the fully connected stage

`ifndef LAYER_MACROS_SVH
`define LAYER_MACROS_SVH

// Neurons per stage and length of the output delay lines
`define LAYER_NEURONS 6

// Q8.8 sample word
`define SAMPLE_W 16
`define FRAC_BITS 8

// Right shifts that scale the error vector
`define TAP_GAIN 3
`define BIAS_GAIN 6

`endif

//--- design/layer_pkg.sv
// Types of the fully connected stage
// Q8.8 sample, tap vector, layer mode and sigmoid segment

`include "layer_macros.svh"

package layer_pkg;

  // Signed Q8.8 word
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // Element j belongs to neuron j
  typedef sample_t [`LAYER_NEURONS-1:0] tap_vec_t;

  typedef enum logic {
    MODE_FORWARD = 1'b0,
    MODE_ERROR   = 1'b1
  } layer_mode_t;

  typedef enum logic [1:0] {
    SEG_LOW    = 2'd0,
    SEG_LINEAR = 2'd1,
    SEG_HIGH   = 2'd2
  } sig_seg_t;

endpackage

//--- design/neuron.sv
// Multiply-accumulate neuron with one register stage
// Saturates the Q8.8 sum to the sample range
`timescale 1ns/1ps
`include "layer_macros.svh"

module neuron (
  input  logic               clk,
  input  logic               reset,
  input  layer_pkg::sample_t data_in,
  input  layer_pkg::sample_t tap,
  input  layer_pkg::sample_t acc_in,
  output layer_pkg::sample_t acc_out
);
  localparam int PROD_W = 2 * `SAMPLE_W;
  localparam logic signed [PROD_W:0] SAT_MAX = (PROD_W + 1)'((1 << (`SAMPLE_W - 1)) - 1);
  localparam logic signed [PROD_W:0] SAT_MIN = -SAT_MAX - 1;

  logic signed [PROD_W-1:0] product;
  logic signed [PROD_W-1:0] scaled;
  logic signed [PROD_W:0]   acc_sum;

  // Full precision product scaled back to Q8.8 by the fraction shift
  assign product = data_in * tap;
  assign scaled  = product >>> `FRAC_BITS;
  assign acc_sum = scaled + acc_in;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_out <= '0;
    end else if (acc_sum > SAT_MAX) begin
      acc_out <= SAT_MAX[`SAMPLE_W-1:0];
    end else if (acc_sum < SAT_MIN) begin
      acc_out <= SAT_MIN[`SAMPLE_W-1:0];
    end else begin
      acc_out <= acc_sum[`SAMPLE_W-1:0];
    end
  end

endmodule

//--- design/sat_add_reg.sv
// Registered saturating adder of two Q8.8 samples
`timescale 1ns/1ps
`include "layer_macros.svh"

module sat_add_reg (
  input  logic               clk,
  input  logic               reset,
  input  layer_pkg::sample_t a,
  input  layer_pkg::sample_t b,
  output layer_pkg::sample_t sum
);
  logic signed [`SAMPLE_W:0]   wide_sum;
  logic signed [`SAMPLE_W-1:0] clamped;

  // Two operand add with one guard bit
  assign wide_sum = a + b;

  always_comb begin
    if (wide_sum[`SAMPLE_W] != wide_sum[`SAMPLE_W-1]) begin
      // Overflow clamps toward the sign of the true result
      clamped = {wide_sum[`SAMPLE_W], {(`SAMPLE_W - 1){~wide_sum[`SAMPLE_W]}}};
    end else begin
      clamped = wide_sum[`SAMPLE_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum <= '0;
    end else begin
      sum <= clamped;
    end
  end

endmodule

//--- design/sigmoid_pwl.sv
// Hard sigmoid in Q8.8 with a registered output
// Flat below -2.0 and above 2.0 with slope 1/4 between
`timescale 1ns/1ps
`include "layer_macros.svh"

module sigmoid_pwl (
  input  logic               clk,
  input  logic               reset,
  input  layer_pkg::sample_t data_in,
  output layer_pkg::sample_t data_out
);
  import layer_pkg::*;

  localparam sample_t ONE  = sample_t'(1 << `FRAC_BITS);
  localparam sample_t HALF = sample_t'(1 << (`FRAC_BITS - 1));
  localparam sample_t TWO  = sample_t'(2 << `FRAC_BITS);

  sig_seg_t seg;
  sample_t  lin_value;

  always_comb begin
    if (data_in <= -TWO) begin
      seg = SEG_LOW;
    end else if (data_in >= TWO) begin
      seg = SEG_HIGH;
    end else begin
      seg = SEG_LINEAR;
    end
  end

  // Reaches 0 and 255 at the segment edges
  assign lin_value = HALF + (data_in >>> 2);

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else begin
      case (seg)
        SEG_LOW:  data_out <= '0;
        SEG_HIGH: data_out <= ONE;
        default:  data_out <= lin_value;
      endcase
    end
  end

endmodule

//--- design/fc_layer.sv
// Fully connected stage with six neurons in Q8.8
// Forward dot products with bias and sigmoid, error mode weight and bias updates
`timescale 1ns/1ps
`include "layer_macros.svh"

module fc_layer (
  input  logic                   clk,
  input  logic                   reset,
  input  layer_pkg::sample_t     data,
  input  layer_pkg::tap_vec_t    taps,
  input  logic                   first,
  input  layer_pkg::sample_t     bias,
  input  layer_pkg::layer_mode_t mode,
  input  logic                   error_first,
  output layer_pkg::tap_vec_t    tap_out,
  output layer_pkg::sample_t     data_out_pre,
  output layer_pkg::sample_t     bias_adder,
  output layer_pkg::sample_t     data_out_bias,
  output layer_pkg::sample_t     data_out
);
  import layer_pkg::*;

  // Error vector scaled for the taps and again for the bias
  tap_vec_t tap_scaled;
  tap_vec_t tap_lat;
  tap_vec_t err_scaled;

  // Per neuron operands and results
  tap_vec_t tap_sel;
  tap_vec_t acc_sel;
  tap_vec_t acc_out;

  // Finished sums and bias corrections leave from index 0
  tap_vec_t out_line;
  tap_vec_t err_line;

  sample_t bias_r;

  //////////////////////////////
  // Error latch
  //////////////////////////////

  always_comb begin
    for (int j = 0; j < `LAYER_NEURONS; j++) begin
      tap_scaled[j] = taps[j] >>> `TAP_GAIN;
      err_scaled[j] = tap_lat[j] >>> `BIAS_GAIN;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tap_lat <= '0;
    end else if (error_first) begin
      tap_lat <= tap_scaled;
    end
  end

  //////////////////////////////
  // Neurons
  //////////////////////////////

  // Error mode adds data times scaled error onto the old weight on taps
  always_comb begin
    for (int j = 0; j < `LAYER_NEURONS; j++) begin
      if (mode == MODE_ERROR) begin
        tap_sel[j] = tap_lat[j];
        acc_sel[j] = taps[j];
      end else begin
        tap_sel[j] = taps[j];
        // Restart the sum on the first sample of a vector
        acc_sel[j] = first ? '0 : acc_out[j];
      end
    end
  end

  for (genvar j = 0; j < `LAYER_NEURONS; j++) begin : g_neuron
    neuron neuron_i (
      .clk     (clk),
      .reset   (reset),
      .data_in (data),
      .tap     (tap_sel[j]),
      .acc_in  (acc_sel[j]),
      .acc_out (acc_out[j])
    );
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tap_out <= '0;
    end else begin
      tap_out <= acc_out;
    end
  end

  //////////////////////////////
  // Output delay lines
  //////////////////////////////

  // A first pulse captures the sums of the previous vector
  always_ff @(posedge clk) begin
    if (reset) begin
      out_line <= '0;
      err_line <= '0;
    end else if (first) begin
      out_line <= acc_out;
      err_line <= err_scaled;
    end else begin
      for (int j = 0; j < `LAYER_NEURONS - 1; j++) begin
        out_line[j] <= out_line[j + 1];
        err_line[j] <= err_line[j + 1];
      end
    end
  end

  // Bias j arrives j cycles after first and lines up with the line head
  always_ff @(posedge clk) begin
    if (reset) begin
      bias_r <= '0;
    end else begin
      bias_r <= bias;
    end
  end

  assign data_out_pre = out_line[0];

  //////////////////////////////
  // Bias add and sigmoid
  //////////////////////////////

  sat_add_reg layer_sum (
    .clk   (clk),
    .reset (reset),
    .a     (out_line[0]),
    .b     (bias_r),
    .sum   (bias_adder)
  );

  // Updated bias from the error vector
  sat_add_reg bias_update (
    .clk   (clk),
    .reset (reset),
    .a     (bias_r),
    .b     (err_line[0]),
    .sum   (data_out_bias)
  );

  sigmoid_pwl sigmoid (
    .clk      (clk),
    .reset    (reset),
    .data_in  (bias_adder),
    .data_out (data_out)
  );

endmodule

//--- testbench/fc_layer_properties.sv
// Concurrent checks on reset, the error latch and the sigmoid range
`timescale 1ns/1ps
`include "layer_macros.svh"

module fc_layer_properties (
  input logic                clk,
  input logic                reset,
  input logic                error_first,
  input layer_pkg::tap_vec_t taps,
  input layer_pkg::tap_vec_t tap_lat,
  input layer_pkg::tap_vec_t tap_out,
  input layer_pkg::sample_t  data_out_pre,
  input layer_pkg::sample_t  bias_adder,
  input layer_pkg::sample_t  data_out_bias,
  input layer_pkg::sample_t  data_out
);
  // All outputs clear one cycle after reset
  assert property (@(posedge clk) reset |=> (tap_out == '0 && data_out_pre == '0 &&
      bias_adder == '0 && data_out_bias == '0 && data_out == '0))
    else $error("outputs not cleared after reset");

  for (genvar j = 0; j < `LAYER_NEURONS; j++) begin : g_latch
    assert property (@(posedge clk) !reset && error_first |=>
        tap_lat[j] == ($signed($past(taps[j])) >>> `TAP_GAIN))
      else $error("error latch %0d does not hold the scaled taps", j);
    assert property (@(posedge clk) !reset && !error_first |=> $stable(tap_lat[j]))
      else $error("error latch %0d changed without error_first", j);
  end

  assert property (@(posedge clk) disable iff (reset) data_out >= 16'sd0 && data_out <= 16'sd256)
    else $error("data_out outside the sigmoid range");

endmodule

bind fc_layer fc_layer_properties props0 (.*);

//--- testbench/fc_layer_tb.sv
// Testbench for the fully connected stage
// Cycle model of the stage rules, directed tests and a watchdog
`timescale 1ns/1ps
`include "layer_macros.svh"

module fc_layer_tb;
  import layer_pkg::*;

  localparam int N = `LAYER_NEURONS;
  // Reset plus the cycles of all tests
  localparam int TEST_CYCLES = 80;

  logic        clk;
  logic        reset;
  sample_t     data;
  tap_vec_t    taps;
  logic        first;
  sample_t     bias;
  layer_mode_t mode;
  logic        error_first;
  tap_vec_t    tap_out;
  sample_t     data_out_pre;
  sample_t     bias_adder;
  sample_t     data_out_bias;
  sample_t     data_out;

  // Expected register contents of the stage
  tap_vec_t acc_m;
  tap_vec_t tap_m;
  tap_vec_t lat_m;
  tap_vec_t line_m;
  tap_vec_t errl_m;
  sample_t  bias_m;
  sample_t  add_m;
  sample_t  upd_m;
  sample_t  out_m;
  // Line entries that still hold sums of the captured vector
  logic [N-1:0] line_ok;
  logic         add_ok;
  logic         out_ok;

  logic [15:0] lfsr;
  int          bias_off [N];
  int          n_checks;
  int          n_errors;

  fc_layer dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic sample_t sat16(int v);
    if (v > 32767) return 16'sh7fff;
    if (v < -32768) return 16'sh8000;
    return sample_t'(v);
  endfunction

  function automatic sample_t sat_add(sample_t a, sample_t b);
    return sat16(int'(a) + int'(b));
  endfunction

  // Q8.8 product scaled back to eight fraction bits and added to the running sum
  function automatic sample_t mac(sample_t acc, sample_t d, sample_t w);
    int prod;
    prod = int'(d) * int'(w);
    return sat16(int'(acc) + (prod >>> `FRAC_BITS));
  endfunction

  function automatic sample_t hard_sig(sample_t x);
    if (x <= -512) return 16'sd0;
    if (x >= 512) return 16'sd256;
    return sample_t'(128 + (int'(x) >>> 2));
  endfunction

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic int rand_signed(int bits);
    int   v;
    logic fb;
    v = 0;
    for (int i = 0; i < bits; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = (v << 1) | int'(fb);
    end
    if (bits > 0 && v >= (1 << (bits - 1))) v = v - (1 << bits);
    return v;
  endfunction

  task automatic check_value(string name, sample_t exp, sample_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic set_idle;
    data        = '0;
    taps        = '0;
    first       = 1'b0;
    bias        = '0;
    mode        = MODE_FORWARD;
    error_first = 1'b0;
  endtask

  // Advance model and DUT by one clock and compare all outputs
  task automatic step_and_check;
    tap_vec_t acc_n;
    for (int j = 0; j < N; j++) begin
      acc_n[j] = (mode == MODE_ERROR) ? mac(taps[j], data, lat_m[j])
                                      : mac(first ? 16'sd0 : acc_m[j], data, taps[j]);
    end
    out_ok = add_ok;
    add_ok = line_ok[0];
    out_m  = hard_sig(add_m);
    add_m  = sat_add(line_m[0], bias_m);
    upd_m  = sat_add(bias_m, errl_m[0]);
    bias_m = bias;
    if (first) begin
      line_m  = acc_m;
      line_ok = '1;
      for (int j = 0; j < N; j++) errl_m[j] = $signed(lat_m[j]) >>> `BIAS_GAIN;
    end else begin
      line_m  = line_m >> `SAMPLE_W;
      errl_m  = errl_m >> `SAMPLE_W;
      line_ok = line_ok >> 1;
    end
    if (error_first) begin
      for (int j = 0; j < N; j++) lat_m[j] = $signed(taps[j]) >>> `TAP_GAIN;
    end
    tap_m = acc_m;
    acc_m = acc_n;
    @(posedge clk);
    #2;
    for (int j = 0; j < N; j++) check_value($sformatf("tap_out[%0d]", j), tap_m[j], tap_out[j]);
    if (line_ok[0]) check_value("data_out_pre", line_m[0], data_out_pre);
    if (add_ok) begin
      check_value("bias_adder", add_m, bias_adder);
      check_value("data_out_bias", upd_m, data_out_bias);
    end
    if (out_ok) check_value("data_out", out_m, data_out);
  endtask

  // Big samples push even neurons to the top and odd ones to the bottom
  task automatic send_vector(int len, int bits, bit big);
    for (int s = 0; s < len; s++) begin
      data = big ? sample_t'(16384 + rand_signed(13)) : sample_t'(rand_signed(bits));
      for (int j = 0; j < N; j++) begin
        taps[j] = sample_t'(rand_signed(bits));
        if (big) taps[j] = sample_t'((j % 2 == 0 ? 1 : -1) * (16384 + rand_signed(13)));
      end
      first = (s == 0);
      bias  = (s < N) ? sample_t'(rand_signed(8) + bias_off[s % N]) : 16'sd0;
      step_and_check();
    end
    first = 1'b0;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset;
    int e0;
    e0 = n_errors;
    for (int j = 0; j < N; j++) check_value($sformatf("tap_out[%0d]", j), 16'sd0, tap_out[j]);
    check_value("data_out_pre", 16'sd0, data_out_pre);
    check_value("bias_adder", 16'sd0, bias_adder);
    check_value("data_out_bias", 16'sd0, data_out_bias);
    check_value("data_out", 16'sd0, data_out);
    repeat (2) step_and_check();
    $display("test reset: %0d mismatches", n_errors - e0);
  endtask

  task automatic test_forward;
    int e0;
    e0 = n_errors;
    repeat (2) send_vector(8, 10, 1'b0);
    $display("test forward dot product: %0d mismatches", n_errors - e0);
  endtask

  // Biases of -6.0 and +6.0 push small sums into both flat segments
  task automatic test_bias_sigmoid;
    int e0;
    e0 = n_errors;
    bias_off[0] = -1536;
    bias_off[1] = 1536;
    repeat (2) send_vector(8, 8, 1'b0);
    bias_off[0] = 0;
    bias_off[1] = 0;
    $display("test bias and sigmoid: %0d mismatches", n_errors - e0);
  endtask

  task automatic test_saturation;
    int e0;
    e0 = n_errors;
    send_vector(8, 0, 1'b1);
    // Biases that drive the clamped sums further out of range
    for (int j = 0; j < N; j++) bias_off[j] = (j % 2 == 0) ? 512 : -512;
    send_vector(8, 8, 1'b0);
    for (int j = 0; j < N; j++) bias_off[j] = 0;
    $display("test saturation: %0d mismatches", n_errors - e0);
  endtask

  task automatic test_error_update;
    int e0;
    e0 = n_errors;
    // Error up to 8.0 is latched as up to 1.0
    for (int j = 0; j < N; j++) taps[j] = sample_t'(rand_signed(12));
    error_first = 1'b1;
    step_and_check();
    error_first = 1'b0;
    mode        = MODE_ERROR;
    repeat (8) begin
      data = sample_t'(rand_signed(10));
      for (int j = 0; j < N; j++) taps[j] = sample_t'(rand_signed(10));
      step_and_check();
    end
    set_idle();
    repeat (2) step_and_check();
    $display("test error mode weight update: %0d mismatches", n_errors - e0);
  endtask

  task automatic test_bias_update;
    int e0;
    e0 = n_errors;
    for (int j = 0; j < N; j++) taps[j] = sample_t'(rand_signed(16));
    error_first = 1'b1;
    step_and_check();
    set_idle();
    send_vector(8, 8, 1'b0);
    set_idle();
    repeat (2) step_and_check();
    $display("test bias update: %0d mismatches", n_errors - e0);
  endtask

  initial begin
    lfsr     = 16'd309;
    n_checks = 0;
    n_errors = 0;
    foreach (bias_off[i]) bias_off[i] = 0;
    {acc_m, tap_m, lat_m, line_m, errl_m} = '0;
    {bias_m, add_m, upd_m, out_m} = '0;
    {line_ok, add_ok, out_ok} = '1;
    reset = 1'b1;
    set_idle();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset();
    test_forward();
    test_bias_sigmoid();
    test_saturation();
    test_error_update();
    test_bias_update();
    $display("checks %0d, mismatches %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(2 * TEST_CYCLES * 40);
    $display("Watchdog expired before the tests completed");
    $display("Errors found");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+design
design/layer_pkg.sv
design/neuron.sv
design/sat_add_reg.sv
design/sigmoid_pwl.sv
design/fc_layer.sv
testbench/fc_layer_properties.sv
testbench/fc_layer_tb.sv

//--- Makefile
TOP = fc_layer_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
	  echo "Simulation failed"; \
	  exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
